// File: flist.f
logic/shell_pkg.sv
logic/spi_rx.sv
logic/user_io_ctrl.sv
logic/event_port.sv
logic/i2s_tx.sv
logic/board_shell.sv
testbench/tb_clock.sv
testbench/tb_board_shell.sv

// File: logic/board_shell.sv
`timescale 1ns/1ps

module board_shell import shell_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   spi_sck,
	input  logic                   spi_ss,
	input  logic                   spi_mosi,
	input  logic [audio_width-1:0] audio,
	input  logic                   audio_valid,
	output logic [31:0]            status,
	output logic [10:0]            ps2_key,
	output logic [24:0]            ps2_mouse,
	output logic                   audio_ready,
	output logic                   i2s_bck,
	output logic                   i2s_lrck,
	output logic                   i2s_data
);

	logic [7:0] rx_byte;
	logic rx_valid;
	logic frame_start;
	logic frame_active;
	logic key_load;
	key_payload_t key_data;
	logic mouse_load;
	mouse_payload_t mouse_data;

	// Control SPI from the I/O controller, oversampled in clk_sys.
	spi_rx u_spi_rx (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.spi_sck      (spi_sck),
		.spi_ss       (spi_ss),
		.spi_mosi     (spi_mosi),
		.rx_byte      (rx_byte),
		.rx_valid     (rx_valid),
		.frame_start  (frame_start),
		.frame_active (frame_active)
	);

	user_io_ctrl u_user_io_ctrl (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.rx_byte      (rx_byte),
		.rx_valid     (rx_valid),
		.frame_start  (frame_start),
		.frame_active (frame_active),
		.status       (status),
		.key_load     (key_load),
		.key_data     (key_data),
		.mouse_load   (mouse_load),
		.mouse_data   (mouse_data)
	);

	event_port #(.payload_t(key_payload_t)) u_key_port (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.load       (key_load),
		.data       (key_data),
		.event_word (ps2_key)
	);

	event_port #(.payload_t(mouse_payload_t)) u_mouse_port (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.load       (mouse_load),
		.data       (mouse_data),
		.event_word (ps2_mouse)
	);

	// Same mix on both channels.
	i2s_tx u_i2s_tx (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.audio       (audio),
		.audio_valid (audio_valid),
		.audio_ready (audio_ready),
		.i2s_bck     (i2s_bck),
		.i2s_lrck    (i2s_lrck),
		.i2s_data    (i2s_data)
	);

endmodule

// File: logic/event_port.sv
`timescale 1ns/1ps

module event_port #(
	parameter type payload_t = logic [7:0]
) (
	input  logic                     clk_sys,
	input  logic                     rst,
	input  logic                     load,
	input  payload_t                 data,
	output logic [$bits(payload_t):0] event_word
);

	payload_t payload;
	logic strobe_level;

	// The core watches the toggle, so equal events back to back still count.
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			payload <= '0;
			strobe_level <= 1'b0;
		end else if (load) begin
			payload <= data;
			strobe_level <= ~strobe_level;
		end
	end

	assign event_word = {strobe_level, payload};

endmodule

// File: logic/i2s_tx.sv
`timescale 1ns/1ps

module i2s_tx import shell_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic [audio_width-1:0] audio,
	input  logic                   audio_valid,
	output logic                   audio_ready,
	output logic                   i2s_bck,
	output logic                   i2s_lrck,
	output logic                   i2s_data
);

	typedef logic [$clog2(i2s_half_bclk)-1:0] div_t;
	typedef logic [$clog2(i2s_word)-1:0] pos_t;

	div_t div_cnt;
	logic div_wrap;
	logic bck_fall;
	logic chan;
	pos_t pos;
	logic chan_nxt;
	pos_t pos_nxt;
	logic word_start;

	logic buf_full;
	logic [audio_width-1:0] buf_data;
	logic [i2s_word-1:0] buf_word;
	logic [i2s_word-1:0] cur_word;
	logic [i2s_word-1:0] left_word;
	logic [i2s_word-1:0] tx_word;
	logic [i2s_word-1:0] shifter;

	assign div_wrap = div_cnt == div_t'(i2s_half_bclk - 1);
	assign bck_fall = div_wrap & i2s_bck;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			div_cnt <= '0;
			i2s_bck <= 1'b0;
		end else if (div_wrap) begin
			div_cnt <= '0;
			i2s_bck <= ~i2s_bck;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Channel bit is the word clock and is low for left.
	assign {chan_nxt, pos_nxt} = {chan, pos} + 1'b1;
	assign i2s_lrck = chan;

	// MSB goes out one bit clock after the word clock edge.
	assign word_start = bck_fall && pos_nxt == pos_t'(1);

	// Offset binary to signed and padded to the channel width.
	assign buf_word = {~buf_data[audio_width-1], buf_data[audio_width-2:0],
		{(i2s_word - audio_width){1'b0}}};
	assign left_word = buf_full ? buf_word : cur_word; // Repeat on underrun.
	assign tx_word = chan_nxt ? cur_word : left_word;

	assign audio_ready = ~buf_full;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			chan <= 1'b0;
			pos <= '0;
			i2s_data <= 1'b0;
			cur_word <= '0;
			buf_full <= 1'b0;
		end else begin
			if (bck_fall) begin
				chan <= chan_nxt;
				pos <= pos_nxt;
				if (word_start) begin
					i2s_data <= tx_word[i2s_word-1];
					if (!chan_nxt) begin
						cur_word <= left_word;
						buf_full <= 1'b0;
					end
				end else begin
					i2s_data <= shifter[i2s_word-1];
				end
			end
			// A sample taken at a word start stays for the next one.
			if (audio_valid && audio_ready)
				buf_full <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (audio_valid && audio_ready)
			buf_data <= audio;
		if (word_start)
			shifter <= {tx_word[i2s_word-2:0], 1'b0};
		else if (bck_fall)
			shifter <= {shifter[i2s_word-2:0], 1'b0};
	end

endmodule

// File: logic/shell_pkg.sv
package shell_pkg;

	// Command bytes from the I/O controller.
	localparam logic [7:0] cmd_status = 8'h1e;
	localparam logic [7:0] cmd_key    = 8'h05;
	localparam logic [7:0] cmd_mouse  = 8'h04;

	// Payload lengths in bytes, status word arrives LSB byte first.
	localparam int status_bytes = 4;
	localparam int key_bytes    = 2;
	localparam int mouse_bytes  = 3;

	localparam int audio_width   = 14; // Core audio mix.
	localparam int i2s_word      = 16; // Bits per channel.
	localparam int i2s_half_bclk = 4;  // clk_sys cycles per half bit clock.

	// Strobe level is added above these by the event port.
	typedef struct packed {
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} key_payload_t;

	typedef struct packed {
		logic [7:0] y;
		logic [7:0] x;
		logic [7:0] flags;
	} mouse_payload_t;

endpackage

// File: logic/spi_rx.sv
`timescale 1ns/1ps

module spi_rx (
	input  logic       clk_sys,
	input  logic       rst,
	input  logic       spi_sck,
	input  logic       spi_ss,
	input  logic       spi_mosi,
	output logic [7:0] rx_byte,
	output logic       rx_valid,
	output logic       frame_start,
	output logic       frame_active
);

	logic sck_s1, sck_s2, sck_d;
	logic ss_s1, ss_s2, ss_d;
	logic mosi_s1, mosi_s2;
	logic sck_rise;
	logic [2:0] bit_cnt;
	logic [6:0] shift;

	// Two flop synchronizers, pins are asynchronous to clk_sys.
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			sck_s1 <= 1'b0;
			sck_s2 <= 1'b0;
			sck_d <= 1'b0;
			ss_s1 <= 1'b1;
			ss_s2 <= 1'b1;
			ss_d <= 1'b1;
		end else begin
			sck_s1 <= spi_sck;
			sck_s2 <= sck_s1;
			sck_d <= sck_s2;
			ss_s1 <= spi_ss;
			ss_s2 <= ss_s1;
			ss_d <= ss_s2;
		end
	end

	always_ff @(posedge clk_sys) begin
		mosi_s1 <= spi_mosi;
		mosi_s2 <= mosi_s1;
	end

	assign sck_rise = sck_s2 & ~sck_d & ~ss_s2;
	assign frame_active = ~ss_s2;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			bit_cnt <= '0;
			rx_valid <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			rx_valid <= sck_rise && bit_cnt == 3'd7;
			frame_start <= ss_d & ~ss_s2; // SS falling edge.
			if (ss_s2)
				bit_cnt <= '0;
			else if (sck_rise)
				bit_cnt <= bit_cnt + 3'd1;
		end
	end

	// MSB first.
	always_ff @(posedge clk_sys) begin
		if (sck_rise) begin
			shift <= {shift[5:0], mosi_s2};
			if (bit_cnt == 3'd7)
				rx_byte <= {shift, mosi_s2};
		end
	end

endmodule

// File: logic/user_io_ctrl.sv
`timescale 1ns/1ps

module user_io_ctrl import shell_pkg::*; (
	input  logic           clk_sys,
	input  logic           rst,
	input  logic [7:0]     rx_byte,
	input  logic           rx_valid,
	input  logic           frame_start,
	input  logic           frame_active,
	output logic [31:0]    status,
	output logic           key_load,
	output key_payload_t   key_data,
	output logic           mouse_load,
	output mouse_payload_t mouse_data
);

	typedef enum logic [1:0] {
		st_idle,
		st_command,
		st_payload
	} state_t;

	state_t state;
	logic [7:0] cmd;
	logic [1:0] byte_cnt;
	logic [1:0] byte_last;
	logic [31:0] asm_word;
	logic [31:0] frame_word;
	logic byte_in;
	logic commit;

	// Bytes shift in from the top so the first one ends up lowest.
	assign frame_word = {rx_byte, asm_word[31:8]};

	// A byte counts only inside a frame that has not just restarted.
	assign byte_in = rx_valid & frame_active & ~frame_start;
	assign commit = byte_in && state == st_payload && byte_cnt == byte_last;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state <= st_idle;
			cmd <= '0;
			byte_cnt <= '0;
			byte_last <= '0;
			status <= '0;
			key_load <= 1'b0;
			mouse_load <= 1'b0;
		end else begin
			key_load <= 1'b0;
			mouse_load <= 1'b0;
			if (frame_start) begin
				state <= st_command;
			end else if (!frame_active) begin
				state <= st_idle; // Short frames are dropped here.
			end else if (byte_in) begin
				case (state)
					st_command: begin
						cmd <= rx_byte;
						byte_cnt <= '0;
						state <= st_payload;
						case (rx_byte)
							cmd_status: byte_last <= 2'(status_bytes - 1);
							cmd_key:    byte_last <= 2'(key_bytes - 1);
							cmd_mouse:  byte_last <= 2'(mouse_bytes - 1);
							default:    state <= st_idle;
						endcase
					end
					st_payload: begin
						byte_cnt <= byte_cnt + 2'd1;
						if (commit) begin
							state <= st_idle;
							case (cmd)
								cmd_status: status <= frame_word;
								cmd_key:    key_load <= 1'b1;
								cmd_mouse:  mouse_load <= 1'b1;
								default:    ;
							endcase
						end
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (byte_in)
			asm_word <= frame_word;
		if (commit && cmd == cmd_key) begin
			key_data.pressed <= frame_word[16];
			key_data.extended <= frame_word[17];
			key_data.code <= frame_word[31:24];
		end
		if (commit && cmd == cmd_mouse) begin
			mouse_data.flags <= frame_word[15:8];
			mouse_data.x <= frame_word[23:16];
			mouse_data.y <= frame_word[31:24];
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the board shell testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_board_shell \
	-o tb_board_shell_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_board_shell_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'All tests passed!'; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: testbench/board_shell_golden.txt
# F nbytes b0 b1 b2 b3 b4 status ps2_key ps2_mouse (frame, nbytes decimal, rest hex)
# A sample i2s_word (14-bit audio mix and its 16-bit I2S channel word, hex)
F 5 1e 78 56 34 12 12345678 000 0000000
F 3 1e aa bb 00 00 12345678 000 0000000
F 5 1e ef be ad de deadbeef 000 0000000
F 3 05 01 1c 00 00 deadbeef 61c 0000000
F 3 05 01 1c 00 00 deadbeef 21c 0000000
F 3 05 02 75 00 00 deadbeef 575 0000000
F 4 04 09 10 f0 00 deadbeef 575 1f01009
F 5 07 1e 22 33 44 deadbeef 575 1f01009
F 4 04 00 ff 01 00 deadbeef 575 001ff00
F 2 05 01 00 00 00 deadbeef 575 001ff00
A 0000 8000
A 3fff 7ffc
A 1234 c8d0
A 2abc 2af0
A 0f0f bc3c
A 3001 4004
A 1fff fffc
A 2001 0004
A 05a5 9694
A 3c3c 70f0

// File: testbench/tb_board_shell.sv
`timescale 1ns/1ps

module tb_board_shell import shell_pkg::*; ();

	localparam int spi_half = 6;       // clk_sys cycles per SPI half period.
	localparam int settle_cycles = 20;
	localparam int cycles_per_line = 2000;

	logic clk_sys, rst;
	logic spi_sck, spi_ss, spi_mosi;
	logic [audio_width-1:0] audio;
	logic audio_valid, audio_ready;
	logic [31:0] status;
	logic [10:0] ps2_key;
	logic [24:0] ps2_mouse;
	logic i2s_bck, i2s_lrck, i2s_data;

	int errors;
	int line_count;
	bit loaded;
	logic [31:0] rnd_state;

	int frame_len[$];
	logic [39:0] frame_bytes[$];
	logic [31:0] exp_status[$];
	logic [10:0] exp_key[$];
	logic [24:0] exp_mouse[$];
	logic [audio_width-1:0] sample_in[$];
	logic [i2s_word-1:0] sample_word[$];

	// I2S receiver state.
	logic [i2s_word-1:0] rx_shift, rx_word, left_rx;
	logic lrck_prev;
	int match_idx; // Index of the last expected word seen or -1.
	int repeats;

	tb_clock u_clock (.clk_sys(clk_sys), .rst(rst));

	board_shell u_dut (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.spi_sck     (spi_sck),
		.spi_ss      (spi_ss),
		.spi_mosi    (spi_mosi),
		.audio       (audio),
		.audio_valid (audio_valid),
		.status      (status),
		.ps2_key     (ps2_key),
		.ps2_mouse   (ps2_mouse),
		.audio_ready (audio_ready),
		.i2s_bck     (i2s_bck),
		.i2s_lrck    (i2s_lrck),
		.i2s_data    (i2s_data)
	);

	task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
			$display("Test failures found");
			$fatal(1, "Stopping at first mismatch.");
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic load_golden();
		int fd;
		int got;
		string line;
		string rest;
		logic [31:0] n, b0, b1, b2, b3, b4, st, ky, ms;
		fd = $fopen("testbench/board_shell_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open testbench/board_shell_golden.txt for reading.");
			$display("Test failures found");
			$fatal(1, "Golden file missing.");
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			rest = line.substr(1, line.len() - 1);
			if (line.getc(0) == "F")
				got = $sscanf(rest, "%d %h %h %h %h %h %h %h %h",
					n, b0, b1, b2, b3, b4, st, ky, ms) == 9 ? 1 : 0;
			else if (line.getc(0) == "A")
				got = $sscanf(rest, "%h %h", b0, st) == 2 ? 2 : 0;
			else
				got = 0;
			if (got == 0) begin
				$display("Malformed line in golden file: %s", line);
				$display("Test failures found");
				$fatal(1, "Bad golden file.");
			end
			if (got == 1) begin
				frame_len.push_back(int'(n));
				frame_bytes.push_back({b0[7:0], b1[7:0], b2[7:0], b3[7:0], b4[7:0]});
				exp_status.push_back(st);
				exp_key.push_back(ky[10:0]);
				exp_mouse.push_back(ms[24:0]);
			end else begin
				sample_in.push_back(b0[audio_width-1:0]);
				sample_word.push_back(st[i2s_word-1:0]);
			end
			line_count++;
		end
		$fclose(fd);
	endtask

	// SPI mode 0, MSB first, SS held low over the whole frame.
	task automatic send_frame(input int nbytes, input logic [39:0] bytes);
		logic [7:0] b;
		@(negedge clk_sys);
		spi_ss = 1'b0;
		repeat (spi_half) @(negedge clk_sys);
		for (int i = 0; i < nbytes; i++) begin
			b = bytes[39 - 8 * i -: 8];
			for (int k = 7; k >= 0; k--) begin
				spi_mosi = b[k];
				repeat (spi_half) @(negedge clk_sys);
				spi_sck = 1'b1;
				repeat (spi_half) @(negedge clk_sys);
				spi_sck = 1'b0;
			end
		end
		repeat (spi_half) @(negedge clk_sys);
		spi_ss = 1'b1;
		spi_mosi = 1'b0;
	endtask

	task automatic play_audio();
		int gap;
		bit taken;
		for (int i = 0; i < sample_in.size(); i++) begin
			rnd_state = xorshift32(rnd_state);
			gap = int'(rnd_state % 384);
			if (i % 3 == 2)
				gap += 520; // Outlasts a frame, so the output repeats.
			repeat (gap) @(negedge clk_sys);
			audio = sample_in[i];
			audio_valid = 1'b1;
			taken = 1'b0;
			while (!taken) begin
				taken = audio_ready; // Value seen at the coming rising edge.
				@(negedge clk_sys);
			end
			audio_valid = 1'b0;
		end
	endtask

	// Each frame is either the next sample or a repeat of the last one.
	task automatic check_frame(input logic [i2s_word-1:0] left,
		input logic [i2s_word-1:0] right);
		logic [i2s_word-1:0] last;
		compare_value(32'(right), 32'(left), "I2S right channel against left");
		last = '0;
		if (match_idx >= 0)
			last = sample_word[match_idx];
		if (match_idx + 1 < sample_word.size() && left == sample_word[match_idx + 1]) begin
			match_idx++;
		end else begin
			if (match_idx >= 0 && match_idx + 1 < sample_word.size())
				repeats++;
			compare_value(32'(left), 32'(last), "I2S word, next sample or repeat");
		end
	endtask

	always @(posedge i2s_bck) begin
		rx_word = {rx_shift[i2s_word-2:0], i2s_data};
		rx_shift = rx_word;
		if (i2s_lrck != lrck_prev) begin
			if (!lrck_prev)
				left_rx = rx_word;
			else
				check_frame(left_rx, rx_word);
		end
		lrck_prev = i2s_lrck;
	end

	initial begin
		wait (loaded);
		repeat (line_count * cycles_per_line) @(posedge clk_sys);
		$display("Timeout: the run did not finish within %0d clock cycles.",
			line_count * cycles_per_line);
		$display("Test failures found");
		$fatal(1, "Watchdog expired.");
	end

	initial begin
		spi_sck = 1'b0;
		spi_ss = 1'b1;
		spi_mosi = 1'b0;
		audio = '0;
		audio_valid = 1'b0;
		errors = 0;
		line_count = 0;
		match_idx = -1;
		repeats = 0;
		rnd_state = 32'd6;
		rx_shift = '0;
		left_rx = '0;
		lrck_prev = 1'b0;
		load_golden();
		loaded = 1'b1;

		@(negedge rst);
		@(negedge clk_sys);
		compare_value(status, 32'd0, "status after reset");
		compare_value(32'(ps2_key), 32'd0, "ps2_key after reset");
		compare_value(32'(ps2_mouse), 32'd0, "ps2_mouse after reset");
		compare_value(32'(audio_ready), 32'd1, "audio_ready after reset");
		compare_value(32'(i2s_bck), 32'd0, "i2s_bck after reset");
		compare_value(32'(i2s_lrck), 32'd0, "i2s_lrck after reset");

		for (int i = 0; i < frame_len.size(); i++) begin
			send_frame(frame_len[i], frame_bytes[i]);
			repeat (settle_cycles) @(negedge clk_sys);
			compare_value(status, exp_status[i], $sformatf("frame %0d status", i));
			compare_value(32'(ps2_key), 32'(exp_key[i]), $sformatf("frame %0d ps2_key", i));
			compare_value(32'(ps2_mouse), 32'(exp_mouse[i]),
				$sformatf("frame %0d ps2_mouse", i));
		end

		play_audio();
		while (match_idx < sample_word.size() - 1)
			@(negedge clk_sys);
		compare_value(32'(repeats > 0), 32'd1, "last sample repeated on a stall");

		if (errors == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("Test failures found");
			$fatal(1, "Checks failed.");
		end
	end

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys,
	output logic rst
);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys; // 8 ns period.
	end

	// Held for 16 rising edges, released on a falling edge.
	initial begin
		rst = 1'b1;
		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		rst = 1'b0;
	end

endmodule
